//--- usb_rx_macros.svh
`ifndef USB_RX_MACROS_SVH
`define USB_RX_MACROS_SVH

// Line sampling
`define USB_CLKS_PER_BIT 8

// Receive buffer entries
`define USB_FIFO_DEPTH 8

// Register bus
`define AXIL_ADDR_W 4
`define AXIL_DATA_W 32

`endif

//--- usb_types_pkg.sv
`default_nettype none

package usb_types_pkg;

    typedef logic [7:0] usb_byte_t;
    typedef logic [15:0] usb_crc_t;

    // Low nibble of the PID byte
    typedef enum logic [3:0] {
        PID_OUT   = 4'b0001,
        PID_IN    = 4'b1001,
        PID_SOF   = 4'b0101,
        PID_SETUP = 4'b1101,
        PID_DATA0 = 4'b0011,
        PID_DATA1 = 4'b1011,
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010,
        PID_STALL = 4'b1110
    } usb_pid_t;

    // Class of the last packet, reported in status
    typedef enum logic [2:0] {
        PKT_NONE      = 3'd0,
        PKT_TOKEN     = 3'd1,
        PKT_DATA0     = 3'd2,
        PKT_DATA1     = 3'd3,
        PKT_HANDSHAKE = 3'd4,
        PKT_BAD_PID   = 3'd5
    } usb_packet_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SYNC,
        ST_PID,
        ST_TOKEN_DATA,
        ST_DATA,
        ST_EOP_WAIT,
        ST_ERROR
    } usb_rx_state_t;

endpackage

`default_nettype wire

//--- usb_bus_pkg.sv
`default_nettype none
`include "usb_rx_macros.svh"

package usb_bus_pkg;

    typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [`AXIL_DATA_W/8-1:0] axil_strb_t;
    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t RESP_OKAY = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // Register map
    localparam axil_addr_t REG_STATUS = 4'h0;
    localparam axil_addr_t REG_DATA = 4'h4;
    localparam axil_addr_t REG_CTRL = 4'h8;

endpackage

`default_nettype wire

//--- usb_line_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "usb_rx_macros.svh"

module usb_line_decoder (
    input  logic tb_clk,
    input  logic tb_n_rst,
    input  logic d_plus,
    input  logic d_minus,
    output logic bit_valid,
    output logic bit_value,
    output logic eop
);

    localparam int PHASE_W = $clog2(`USB_CLKS_PER_BIT);
    localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`USB_CLKS_PER_BIT - 1);
    localparam logic [PHASE_W-1:0] PHASE_MID = PHASE_W'(`USB_CLKS_PER_BIT / 2);

    logic dp_meta;
    logic dp_sync;
    logic dp_prev;
    logic dm_meta;
    logic dm_sync;
    logic dm_prev;
    logic [PHASE_W-1:0] phase;
    logic [1:0] se0_cnt;
    logic last_level;
    logic line_edge;
    logic sample;
    logic se0;

    // ****************************************
    // Synchroniser, line idles in J
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            dp_meta <= 1'b1;
            dp_sync <= 1'b1;
            dp_prev <= 1'b1;
            dm_meta <= 1'b0;
            dm_sync <= 1'b0;
            dm_prev <= 1'b0;
        end else begin
            dp_meta <= d_plus;
            dp_sync <= dp_meta;
            dp_prev <= dp_sync;
            dm_meta <= d_minus;
            dm_sync <= dm_meta;
            dm_prev <= dm_sync;
        end
    end

    assign line_edge = (dp_sync != dp_prev) || (dm_sync != dm_prev);
    assign sample = (phase == PHASE_MID) && !line_edge;
    assign se0 = !dp_sync && !dm_sync;

    // Bit phase restarts on every transition
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            phase <= '0;
        end else if (line_edge) begin
            phase <= PHASE_W'(1);
        end else if (phase == PHASE_LAST) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // ****************************************
    // NRZI decode and SE0 counting
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            bit_valid <= 1'b0;
            bit_value <= 1'b0;
            eop <= 1'b0;
            se0_cnt <= '0;
            last_level <= 1'b1;
        end else begin
            bit_valid <= 1'b0;
            eop <= 1'b0;
            if (sample) begin
                if (se0) begin
                    if (se0_cnt != 2'd2) begin
                        se0_cnt <= se0_cnt + 1'b1;
                    end
                    if (se0_cnt == 2'd1) begin
                        eop <= 1'b1;
                        // Bus returns to J after the packet
                        last_level <= 1'b1;
                    end
                end else begin
                    se0_cnt <= '0;
                    bit_valid <= 1'b1;
                    bit_value <= (dp_sync == last_level);
                    last_level <= dp_sync;
                end
            end
        end
    end

    assert property (@(posedge tb_clk) disable iff (!tb_n_rst) !(bit_valid && eop));

endmodule

`default_nettype wire

//--- usb_crc16.sv
`timescale 1ns/1ps
`default_nettype none

module usb_crc16 (
    input  logic tb_clk,
    input  logic tb_n_rst,
    input  logic crc_clear,
    input  logic crc_enable,
    input  logic bit_value,
    output logic crc_ok
);

    import usb_types_pkg::*;

    // x^16 + x^15 + x^2 + 1
    localparam usb_crc_t CRC_POLY = 16'h8005;
    localparam usb_crc_t CRC_RESIDUE = 16'h800D;

    usb_crc_t crc;
    logic feedback;

    assign feedback = crc[15] ^ bit_value;

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            crc <= '1;
        end else if (crc_clear) begin
            crc <= '1;
        end else if (crc_enable) begin
            crc <= {crc[14:0], 1'b0} ^ (feedback ? CRC_POLY : '0);
        end
    end

    // Data plus inverted CRC leaves the fixed residue
    assign crc_ok = (crc == CRC_RESIDUE);

endmodule

`default_nettype wire

//--- usb_rx_control.sv
`timescale 1ns/1ps
`default_nettype none

module usb_rx_control (
    input  logic tb_clk,
    input  logic tb_n_rst,
    input  logic bit_valid,
    input  logic bit_value,
    input  logic eop,
    input  logic crc_ok,
    output logic crc_clear,
    output logic crc_enable,
    output logic w_enable,
    output usb_types_pkg::usb_byte_t w_data,
    output logic packet_done,
    output logic rx_error,
    output usb_types_pkg::usb_packet_t rx_packet
);

    import usb_types_pkg::*;

    // Seven zeros then a one, LSB first
    localparam usb_byte_t SYNC_PATTERN = 8'h80;

    usb_rx_state_t state;
    usb_byte_t shift;
    usb_byte_t byte_next;
    usb_byte_t dly0;
    usb_byte_t dly1;
    usb_pid_t pid_code;
    logic [2:0] bit_cnt;
    logic [1:0] fill;
    logic byte_done;
    logic payload_byte;
    logic pid_ok;
    logic end_error;

    assign byte_next = {bit_value, shift[7:1]};
    assign byte_done = bit_valid && (bit_cnt == 3'd7);
    assign payload_byte = byte_done && (state == ST_DATA || state == ST_TOKEN_DATA);
    assign pid_ok = (byte_next[7:4] == ~byte_next[3:0]);
    assign pid_code = usb_pid_t'(byte_next[3:0]);
    assign crc_clear = (state == ST_PID);
    assign crc_enable = bit_valid && (state == ST_DATA);

    always_comb begin
        case (state)
            ST_PID, ST_ERROR: end_error = 1'b1;
            ST_DATA: end_error = !crc_ok || (bit_cnt != 3'd0);
            ST_TOKEN_DATA: end_error = (bit_cnt != 3'd0);
            default: end_error = 1'b0;
        endcase
    end

    // ****************************************
    // Packet FSM
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            state <= ST_IDLE;
            shift <= '0;
            bit_cnt <= '0;
            fill <= '0;
            rx_packet <= PKT_NONE;
            w_enable <= 1'b0;
            packet_done <= 1'b0;
            rx_error <= 1'b0;
        end else begin
            w_enable <= 1'b0;
            packet_done <= 1'b0;
            rx_error <= 1'b0;
            if (eop) begin
                // A sync that never completed is just line noise
                if (state != ST_IDLE && state != ST_SYNC) begin
                    packet_done <= 1'b1;
                    rx_error <= end_error;
                end
                state <= ST_IDLE;
            end else if (bit_valid) begin
                shift <= byte_next;
                case (state)
                    ST_IDLE: begin
                        if (!bit_value) begin
                            state <= ST_SYNC;
                        end
                    end
                    ST_SYNC: begin
                        if (bit_value && byte_next == SYNC_PATTERN) begin
                            state <= ST_PID;
                            bit_cnt <= '0;
                            fill <= '0;
                            rx_packet <= PKT_NONE;
                        end else if (bit_value) begin
                            state <= ST_IDLE;
                        end
                    end
                    ST_PID: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (byte_done && !pid_ok) begin
                            rx_packet <= PKT_BAD_PID;
                            state <= ST_ERROR;
                        end else if (byte_done) begin
                            case (pid_code)
                                PID_OUT, PID_IN, PID_SOF, PID_SETUP: begin
                                    rx_packet <= PKT_TOKEN;
                                    state <= ST_TOKEN_DATA;
                                end
                                PID_DATA0: begin
                                    rx_packet <= PKT_DATA0;
                                    state <= ST_DATA;
                                end
                                PID_DATA1: begin
                                    rx_packet <= PKT_DATA1;
                                    state <= ST_DATA;
                                end
                                PID_ACK, PID_NAK, PID_STALL: begin
                                    rx_packet <= PKT_HANDSHAKE;
                                    state <= ST_EOP_WAIT;
                                end
                                default: begin
                                    rx_packet <= PKT_BAD_PID;
                                    state <= ST_ERROR;
                                end
                            endcase
                        end
                    end
                    ST_TOKEN_DATA, ST_DATA: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (byte_done && fill == 2'd2) begin
                            w_enable <= 1'b1;
                        end else if (byte_done) begin
                            fill <= fill + 1'b1;
                        end
                    end
                    // Handshakes carry no payload
                    ST_EOP_WAIT: state <= ST_ERROR;
                    default: ;
                endcase
            end
        end
    end

    // Two-byte delay keeps the CRC bytes out of the FIFO
    always_ff @(posedge tb_clk) begin
        if (payload_byte) begin
            dly0 <= byte_next;
            dly1 <= dly0;
            w_data <= dly1;
        end
    end

    assert property (@(posedge tb_clk) disable iff (!tb_n_rst)
        w_enable |-> (state == ST_DATA || state == ST_TOKEN_DATA));

endmodule

`default_nettype wire

//--- usb_rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "usb_rx_macros.svh"

module usb_rx_fifo (
    input  logic tb_clk,
    input  logic tb_n_rst,
    input  logic w_enable,
    input  usb_types_pkg::usb_byte_t w_data,
    input  logic r_enable,
    output usb_types_pkg::usb_byte_t r_data,
    output logic empty,
    output logic full,
    output logic overflow,
    input  logic clear_flags
);

    import usb_types_pkg::*;

    localparam int DEPTH = `USB_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    usb_byte_t mem [DEPTH];
    logic [PTR_W-1:0] w_ptr;
    logic [PTR_W-1:0] r_ptr;
    logic [CNT_W-1:0] count;
    logic do_write;
    logic do_read;

    assign empty = (count == '0);
    assign full = (count == CNT_W'(DEPTH));
    assign do_write = w_enable && !full;
    assign do_read = r_enable && !empty;
    assign r_data = mem[r_ptr];

    always_ff @(posedge tb_clk) begin
        if (do_write) begin
            mem[w_ptr] <= w_data;
        end
    end

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            w_ptr <= '0;
            r_ptr <= '0;
            count <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_write) begin
                w_ptr <= (w_ptr == PTR_LAST) ? '0 : w_ptr + 1'b1;
            end
            if (do_read) begin
                r_ptr <= (r_ptr == PTR_LAST) ? '0 : r_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
            // Dropped byte wins over a clear in the same cycle
            if (w_enable && full) begin
                overflow <= 1'b1;
            end else if (clear_flags) begin
                overflow <= 1'b0;
            end
        end
    end

    assert property (@(posedge tb_clk) disable iff (!tb_n_rst) count <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

//--- usb_rx_axil.sv
`timescale 1ns/1ps
`default_nettype none

module usb_rx_axil (
    input  logic tb_clk,
    input  logic tb_n_rst,
    input  usb_bus_pkg::axil_addr_t awaddr,
    input  logic awvalid,
    output logic awready,
    input  usb_bus_pkg::axil_data_t wdata,
    input  usb_bus_pkg::axil_strb_t wstrb,
    input  logic wvalid,
    output logic wready,
    output usb_bus_pkg::axil_resp_t bresp,
    output logic bvalid,
    input  logic bready,
    input  usb_bus_pkg::axil_addr_t araddr,
    input  logic arvalid,
    output logic arready,
    output usb_bus_pkg::axil_data_t rdata,
    output usb_bus_pkg::axil_resp_t rresp,
    output logic rvalid,
    input  logic rready,
    input  usb_types_pkg::usb_byte_t fifo_data,
    input  logic fifo_empty,
    input  logic fifo_overflow,
    output logic fifo_pop,
    input  logic packet_done,
    input  logic rx_error,
    input  usb_types_pkg::usb_packet_t rx_packet,
    output logic clear_flags
);

    import usb_types_pkg::*;
    import usb_bus_pkg::*;

    usb_packet_t last_class;
    axil_data_t status_word;
    axil_data_t rd_value;
    axil_resp_t rd_resp;
    logic wr_hs;
    logic rd_hs;
    logic done_flag;
    logic error_flag;

    // Address and data are taken together
    assign wr_hs = awvalid && wvalid && !bvalid;
    assign awready = wr_hs;
    assign wready = wr_hs;
    assign arready = !rvalid;
    assign rd_hs = arvalid && arready;
    assign fifo_pop = rd_hs && (araddr == REG_DATA) && !fifo_empty;

    always_comb begin
        status_word = '0;
        status_word[0] = fifo_empty;
        status_word[1] = done_flag;
        status_word[2] = error_flag;
        status_word[3] = fifo_overflow;
        status_word[6:4] = last_class;
    end

    always_comb begin
        rd_value = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            REG_STATUS: rd_value = status_word;
            REG_DATA: rd_value = fifo_empty ? '0 : axil_data_t'(fifo_data);
            REG_CTRL: rd_value = '0;
            default: rd_resp = RESP_SLVERR;
        endcase
    end

    // ****************************************
    // Responses and sticky flags
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            rvalid <= 1'b0;
            rresp <= RESP_OKAY;
            bvalid <= 1'b0;
            bresp <= RESP_OKAY;
            clear_flags <= 1'b0;
            done_flag <= 1'b0;
            error_flag <= 1'b0;
            last_class <= PKT_NONE;
        end else begin
            clear_flags <= 1'b0;
            if (rd_hs) begin
                rvalid <= 1'b1;
                rresp <= rd_resp;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_hs && awaddr == REG_CTRL) begin
                bvalid <= 1'b1;
                bresp <= RESP_OKAY;
                clear_flags <= wdata[0] && wstrb[0];
            end else if (wr_hs) begin
                bvalid <= 1'b1;
                bresp <= RESP_SLVERR;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (packet_done) begin
                done_flag <= 1'b1;
                last_class <= rx_packet;
            end else if (clear_flags) begin
                done_flag <= 1'b0;
            end
            if (rx_error) begin
                error_flag <= 1'b1;
            end else if (clear_flags) begin
                error_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge tb_clk) begin
        if (rd_hs) begin
            rdata <= rd_value;
        end
    end

    assert property (@(posedge tb_clk) disable iff (!tb_n_rst)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

//--- usb_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module usb_rx_top (
    input  logic tb_clk,
    input  logic tb_n_rst,
    input  logic d_plus,
    input  logic d_minus,
    input  usb_bus_pkg::axil_addr_t awaddr,
    input  logic awvalid,
    output logic awready,
    input  usb_bus_pkg::axil_data_t wdata,
    input  usb_bus_pkg::axil_strb_t wstrb,
    input  logic wvalid,
    output logic wready,
    output usb_bus_pkg::axil_resp_t bresp,
    output logic bvalid,
    input  logic bready,
    input  usb_bus_pkg::axil_addr_t araddr,
    input  logic arvalid,
    output logic arready,
    output usb_bus_pkg::axil_data_t rdata,
    output usb_bus_pkg::axil_resp_t rresp,
    output logic rvalid,
    input  logic rready
);

    import usb_types_pkg::*;

    logic bit_valid;
    logic bit_value;
    logic eop;
    logic crc_clear;
    logic crc_enable;
    logic crc_ok;
    logic w_enable;
    usb_byte_t w_data;
    usb_byte_t r_data;
    logic r_enable;
    logic empty;
    logic overflow;
    logic packet_done;
    logic rx_error;
    usb_packet_t rx_packet;
    logic clear_flags;

    usb_line_decoder i_decoder (
        .tb_clk    (tb_clk),
        .tb_n_rst  (tb_n_rst),
        .d_plus    (d_plus),
        .d_minus   (d_minus),
        .bit_valid (bit_valid),
        .bit_value (bit_value),
        .eop       (eop)
    );

    usb_crc16 i_crc (
        .tb_clk     (tb_clk),
        .tb_n_rst   (tb_n_rst),
        .crc_clear  (crc_clear),
        .crc_enable (crc_enable),
        .bit_value  (bit_value),
        .crc_ok     (crc_ok)
    );

    usb_rx_control i_control (
        .tb_clk      (tb_clk),
        .tb_n_rst    (tb_n_rst),
        .bit_valid   (bit_valid),
        .bit_value   (bit_value),
        .eop         (eop),
        .crc_ok      (crc_ok),
        .crc_clear   (crc_clear),
        .crc_enable  (crc_enable),
        .w_enable    (w_enable),
        .w_data      (w_data),
        .packet_done (packet_done),
        .rx_error    (rx_error),
        .rx_packet   (rx_packet)
    );

    // Control never stalls, so full stays unconnected
    usb_rx_fifo i_fifo (
        .tb_clk      (tb_clk),
        .tb_n_rst    (tb_n_rst),
        .w_enable    (w_enable),
        .w_data      (w_data),
        .r_enable    (r_enable),
        .r_data      (r_data),
        .empty       (empty),
        .full        (),
        .overflow    (overflow),
        .clear_flags (clear_flags)
    );

    usb_rx_axil i_axil (
        .tb_clk        (tb_clk),
        .tb_n_rst      (tb_n_rst),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .fifo_data     (r_data),
        .fifo_empty    (empty),
        .fifo_overflow (overflow),
        .fifo_pop      (r_enable),
        .packet_done   (packet_done),
        .rx_error      (rx_error),
        .rx_packet     (rx_packet),
        .clear_flags   (clear_flags)
    );

endmodule

`default_nettype wire

//--- tb_usb_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "usb_rx_macros.svh"

module tb_usb_rx;

    import usb_types_pkg::*;
    import usb_bus_pkg::*;

    localparam int CLK_HALF = 10;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 16;
    localparam int HANDSHAKE_TIMEOUT = 100;
    localparam int POLL_LIMIT = 50;
    localparam usb_byte_t SYNC_BYTE = 8'h80;
    localparam axil_addr_t ADDR_UNMAPPED = 4'hC;

    typedef struct packed {
        usb_byte_t pid;
        logic [2:0] len;
        logic corrupt;
        usb_packet_t cls;
        logic drain;
    } row_t;

    // PID byte, payload length, corrupt CRC, class, read back after the packet
    localparam int NUM_ROWS = 10;
    localparam row_t ROWS [NUM_ROWS] = '{
        '{8'hC3, 3'd4, 1'b0, PKT_DATA0, 1'b1},
        '{8'h4B, 3'd6, 1'b0, PKT_DATA1, 1'b1},
        '{8'hC3, 3'd0, 1'b0, PKT_DATA0, 1'b1},
        '{8'h4B, 3'd3, 1'b1, PKT_DATA1, 1'b1},
        '{8'hD3, 3'd5, 1'b0, PKT_BAD_PID, 1'b1},
        '{8'hD2, 3'd0, 1'b0, PKT_HANDSHAKE, 1'b1},
        '{8'hE1, 3'd3, 1'b0, PKT_TOKEN, 1'b1},
        '{8'hC3, 3'd5, 1'b0, PKT_DATA0, 1'b0},
        '{8'h4B, 3'd6, 1'b0, PKT_DATA1, 1'b1},
        '{8'hC3, 3'd1, 1'b0, PKT_DATA0, 1'b1}
    };

    logic tb_clk;
    logic tb_n_rst;
    logic d_plus;
    logic d_minus;
    axil_addr_t awaddr;
    logic awvalid;
    logic awready;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic wvalid;
    logic wready;
    axil_resp_t bresp;
    logic bvalid;
    logic bready;
    axil_addr_t araddr;
    logic arvalid;
    logic arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic rvalid;
    logic rready;

    integer seed;
    usb_byte_t exp_q [$];
    usb_packet_t last_class;

    usb_rx_top i_dut (
        .tb_clk   (tb_clk),
        .tb_n_rst (tb_n_rst),
        .d_plus   (d_plus),
        .d_minus  (d_minus),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready)
    );

    always #CLK_HALF tb_clk = ~tb_clk;

    // ****************************************
    // Checking
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input axil_data_t actual,
            input axil_data_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    function automatic axil_data_t status_word(input logic is_empty, input logic done,
            input logic error, input logic overflow, input usb_packet_t cls);
        axil_data_t word;
        word = '0;
        word[0] = is_empty;
        word[1] = done;
        word[2] = error;
        word[3] = overflow;
        word[6:4] = cls;
        return word;
    endfunction

    // Reflected USB CRC16, returned inverted
    function automatic logic [15:0] ref_crc16(input usb_byte_t data [$]);
        logic [15:0] crc;
        crc = 16'hFFFF;
        foreach (data[i]) begin
            for (int k = 0; k < 8; k++) begin
                if (crc[0] ^ data[i][k]) begin
                    crc = (crc >> 1) ^ 16'hA001;
                end else begin
                    crc = crc >> 1;
                end
            end
        end
        return ~crc;
    endfunction

    // ****************************************
    // Line driver
    task automatic drive_line(input logic dp, input logic dm);
        @(posedge tb_clk);
        #DRIVE_DELAY;
        d_plus = dp;
        d_minus = dm;
        repeat (`USB_CLKS_PER_BIT - 1) @(posedge tb_clk);
    endtask

    task automatic send_packet(input usb_byte_t pid, input usb_byte_t data [$]);
        usb_byte_t frame [$];
        logic level;
        frame = data;
        frame.push_front(pid);
        frame.push_front(SYNC_BYTE);
        level = 1'b1;
        foreach (frame[n]) begin
            for (int k = 0; k < 8; k++) begin
                // A zero toggles the line
                if (!frame[n][k]) begin
                    level = ~level;
                end
                drive_line(level, ~level);
            end
        end
        drive_line(1'b0, 1'b0);
        drive_line(1'b0, 1'b0);
        drive_line(1'b1, 1'b0);
    endtask

    // ****************************************
    // AXI4-Lite master
    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
            output axil_resp_t resp);
        int cycles;
        @(posedge tb_clk);
        #DRIVE_DELAY;
        awaddr = addr;
        awvalid = 1'b1;
        wdata = data;
        wstrb = '1;
        wvalid = 1'b1;
        bready = 1'b1;
        cycles = 0;
        @(negedge tb_clk);
        while (!(awready && wready)) begin
            cycles++;
            if (cycles > HANDSHAKE_TIMEOUT) begin
                fail_run("Write address and data were never accepted");
            end
            @(negedge tb_clk);
        end
        @(posedge tb_clk);
        #DRIVE_DELAY;
        awvalid = 1'b0;
        wvalid = 1'b0;
        cycles = 0;
        @(negedge tb_clk);
        while (!bvalid) begin
            cycles++;
            if (cycles > HANDSHAKE_TIMEOUT) begin
                fail_run("Write response never arrived");
            end
            @(negedge tb_clk);
        end
        resp = bresp;
        @(posedge tb_clk);
        #DRIVE_DELAY;
        bready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
            output axil_resp_t resp);
        int cycles;
        @(posedge tb_clk);
        #DRIVE_DELAY;
        araddr = addr;
        arvalid = 1'b1;
        rready = 1'b0;
        cycles = 0;
        @(negedge tb_clk);
        while (!arready) begin
            cycles++;
            if (cycles > HANDSHAKE_TIMEOUT) begin
                fail_run("Read address was never accepted");
            end
            @(negedge tb_clk);
        end
        @(posedge tb_clk);
        #DRIVE_DELAY;
        arvalid = 1'b0;
        cycles = 0;
        @(negedge tb_clk);
        while (!rvalid) begin
            cycles++;
            if (cycles > HANDSHAKE_TIMEOUT) begin
                fail_run("Read data never arrived");
            end
            @(negedge tb_clk);
        end
        // One cycle of R back-pressure before taking the data
        @(posedge tb_clk);
        #DRIVE_DELAY;
        rready = 1'b1;
        @(negedge tb_clk);
        check_value("rvalid", axil_data_t'(rvalid), axil_data_t'(1'b1));
        data = rdata;
        resp = rresp;
        @(posedge tb_clk);
        #DRIVE_DELAY;
        rready = 1'b0;
    endtask

    task automatic wait_packet_done(output axil_data_t status);
        axil_resp_t resp;
        int polls;
        polls = 0;
        axil_read(REG_STATUS, status, resp);
        while (!status[1]) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                fail_run("Packet done never showed up in STATUS");
            end
            axil_read(REG_STATUS, status, resp);
        end
    endtask

    // ****************************************
    // One table row
    task automatic run_row(input row_t row);
        usb_byte_t payload [$];
        usb_byte_t wire_bytes [$];
        usb_byte_t expected;
        logic [15:0] crc;
        axil_data_t value;
        axil_resp_t resp;
        int stored;
        logic exp_error;
        logic exp_overflow;

        axil_write(REG_CTRL, 32'h1, resp);
        check_value("bresp", axil_data_t'(resp), axil_data_t'(RESP_OKAY));
        axil_read(REG_STATUS, value, resp);
        check_value("status", value,
            status_word(exp_q.size() == 0, 1'b0, 1'b0, 1'b0, last_class));

        for (int i = 0; i < int'(row.len); i++) begin
            payload.push_back(usb_byte_t'($random(seed)));
        end
        wire_bytes = payload;
        stored = 0;
        if (row.cls == PKT_DATA0 || row.cls == PKT_DATA1) begin
            crc = ref_crc16(payload);
            if (row.corrupt) begin
                crc[0] = ~crc[0];
            end
            wire_bytes.push_back(crc[7:0]);
            wire_bytes.push_back(crc[15:8]);
            stored = payload.size();
        end else if (row.cls == PKT_TOKEN && row.len > 3'd2) begin
            // Last two token bytes stay in the delay line
            stored = int'(row.len) - 2;
        end
        send_packet(row.pid, wire_bytes);

        exp_overflow = 1'b0;
        for (int i = 0; i < stored; i++) begin
            if (exp_q.size() < `USB_FIFO_DEPTH) begin
                exp_q.push_back(payload[i]);
            end else begin
                exp_overflow = 1'b1;
            end
        end
        exp_error = row.corrupt || (row.cls == PKT_BAD_PID);
        last_class = row.cls;

        wait_packet_done(value);
        check_value("status", value,
            status_word(exp_q.size() == 0, 1'b1, exp_error, exp_overflow, row.cls));

        if (row.drain) begin
            while (exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                axil_read(REG_DATA, value, resp);
                check_value("rdata", value, axil_data_t'(expected));
                check_value("rresp", axil_data_t'(resp), axil_data_t'(RESP_OKAY));
            end
            // Empty FIFO reads as zero
            axil_read(REG_DATA, value, resp);
            check_value("rdata", value, '0);
            axil_read(REG_STATUS, value, resp);
            check_value("status", value,
                status_word(1'b1, 1'b1, exp_error, exp_overflow, row.cls));
        end
    endtask

    initial begin
        axil_data_t value;
        axil_resp_t resp;

        tb_clk = 1'b0;
        tb_n_rst = 1'b0;
        d_plus = 1'b1;
        d_minus = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        seed = 71604;
        last_class = PKT_NONE;

        repeat (RESET_CYCLES) @(posedge tb_clk);
        #DRIVE_DELAY;
        tb_n_rst = 1'b1;
        repeat (2) @(posedge tb_clk);

        axil_read(REG_STATUS, value, resp);
        check_value("status", value, status_word(1'b1, 1'b0, 1'b0, 1'b0, PKT_NONE));
        check_value("rresp", axil_data_t'(resp), axil_data_t'(RESP_OKAY));

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(ROWS[i]);
        end

        // Bus errors
        axil_read(ADDR_UNMAPPED, value, resp);
        check_value("rresp", axil_data_t'(resp), axil_data_t'(RESP_SLVERR));
        axil_write(REG_STATUS, 32'h1, resp);
        check_value("bresp", axil_data_t'(resp), axil_data_t'(RESP_SLVERR));

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
usb_types_pkg.sv
usb_bus_pkg.sv
usb_line_decoder.sv
usb_crc16.sv
usb_rx_control.sv
usb_rx_fifo.sv
usb_rx_axil.sv
usb_rx_top.sv
tb_usb_rx.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps
TOP = tb_usb_rx
FILELIST = project.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "FAIL: run did not complete"; exit 1; fi
	@echo "PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
